// File: sources.f
mem_pkg.sv
lsu.sv
data_sram.sv
lsu_top.sv
tb_lsu_top.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run by its log

verilator --binary --timing -f sources.f --top-module tb_lsu_top > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_lsu_top > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top
  import mem_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 100;

  logic  clk;
  logic  arst_n;
  word_t raddr;
  func_t rfunc;
  logic  rreq_valid;
  logic  rreq_ready;
  word_t rdata;
  logic  rres_valid;
  logic  rres_ready;
  word_t waddr;
  word_t wdata;
  func_t wfunc;
  logic  wreq_valid;
  logic  wreq_ready;
  logic  wres_valid;
  logic  wres_ready;

  // mirror of every store the memory has taken
  word_t mem_ref [MEM_WORDS];
  word_t seed = 32'hbe6d;

  // hand-off from the load driver to the compare process
  string cmp_name;
  word_t cmp_exp;
  word_t cmp_act;
  event  cmp_ev;

  lsu_top DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .waddr      (waddr),
    .wdata      (wdata),
    .wfunc      (wfunc),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function word_t lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // expected load value picked out of a memory word
  function automatic word_t load_ref(input word_t word, input logic [1:0] off,
                                     input func_t func);
    int          o;
    logic [7:0]  b;
    logic [15:0] h;
    o = int'(off);
    b = word[8*o +: 8];
    h = word[16*(o/2) +: 16];
    case (func)
      LD_BS:   return b[7] ? {24'hffffff, b} : {24'h000000, b};
      LD_BU:   return {24'h000000, b};
      LD_HS:   return h[15] ? {16'hffff, h} : {16'h0000, h};
      LD_HU:   return {16'h0000, h};
      default: return word;
    endcase
  endfunction

  // memory word after a store, one byte lane at a time
  function automatic word_t store_ref(input word_t old, input word_t data,
                                      input logic [1:0] off, input func_t func);
    word_t res;
    int    n;
    int    o;
    res = old;
    o = int'(off);
    case (func)
      ST_B:    n = 1;
      ST_H:    n = 2;
      default: n = 4;
    endcase
    for (int i = 0; i < 4; i++) begin
      if (i >= o && i < o + n) begin
        res[8*i +: 8] = data[8*(i-o) +: 8];
      end
    end
    return res;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic expect_idle(input string name);
    check_flag({name, " rres_valid"}, 1'b0, rres_valid);
    check_flag({name, " wres_valid"}, 1'b0, wres_valid);
    check_flag({name, " rreq_ready"}, 1'b1, rreq_ready);
    check_flag({name, " wreq_ready"}, 1'b1, wreq_ready);
  endtask

  // called right after a falling edge
  // with hold > 0 the same store is left pending and the caller issues it again
  task automatic store_op(input word_t addr, input word_t data, input func_t func,
                          input int hold, input string name);
    int t;
    waddr      = addr;
    wdata      = data;
    wfunc      = func;
    wreq_valid = 1'b1;
    wres_ready = (hold == 0);
    t = 0;
    while (!wreq_ready) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT_CYCLES) stop_on_error({name, ": store request was never accepted"});
    end
    check_flag({name, " wres_valid before accept"}, 1'b0, wres_valid);
    mem_ref[addr[MEM_AW+1:2]] = store_ref(mem_ref[addr[MEM_AW+1:2]], data, addr[1:0], func);
    @(negedge clk);
    wreq_valid = 1'b0;
    check_flag({name, " wres_valid one edge after accept"}, 1'b1, wres_valid);
    if (hold > 0) begin
      wreq_valid = 1'b1;
      repeat (hold) begin
        @(negedge clk);
        check_flag({name, " wres_valid held"}, 1'b1, wres_valid);
        check_flag({name, " second store refused"}, 1'b0, wreq_ready);
      end
      wres_ready = 1'b1;
    end
    @(negedge clk);
    check_flag({name, " wres_valid cleared"}, 1'b0, wres_valid);
  endtask

  // same calling rules as store_op
  task automatic load_op(input word_t addr, input func_t func, input int hold,
                         input string name);
    word_t exp;
    word_t held;
    int    t;
    exp        = load_ref(mem_ref[addr[MEM_AW+1:2]], addr[1:0], func);
    raddr      = addr;
    rfunc      = func;
    rreq_valid = 1'b1;
    rres_ready = (hold == 0);
    t = 0;
    while (!rreq_ready) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT_CYCLES) stop_on_error({name, ": load request was never accepted"});
    end
    check_flag({name, " rres_valid before accept"}, 1'b0, rres_valid);
    @(negedge clk);
    rreq_valid = 1'b0;
    check_flag({name, " rres_valid one edge after accept"}, 1'b1, rres_valid);
    held = rdata;
    if (hold > 0) begin
      rreq_valid = 1'b1;
      repeat (hold) begin
        @(negedge clk);
        check_flag({name, " rres_valid held"}, 1'b1, rres_valid);
        check_word({name, " rdata stable"}, held, rdata);
        check_flag({name, " second load refused"}, 1'b0, rreq_ready);
      end
      rres_ready = 1'b1;
    end
    cmp_name = name;
    cmp_exp  = exp;
    cmp_act  = rdata;
    -> cmp_ev;
    @(negedge clk);
    check_flag({name, " rres_valid cleared"}, 1'b0, rres_valid);
  endtask

  // compares every completed load
  initial begin
    forever begin
      @(cmp_ev);
      check_word(cmp_name, cmp_exp, cmp_act);
    end
  end

  initial begin
    word_t addrs [16];
    word_t base;
    word_t data;
    int    hold;
    arst_n     = 1'b0;
    raddr      = '0;
    rfunc      = LD_W;
    rreq_valid = 1'b0;
    rres_ready = 1'b1;
    waddr      = '0;
    wdata      = '0;
    wfunc      = ST_W;
    wreq_valid = 1'b0;
    wres_ready = 1'b1;
    repeat (3) begin
      @(negedge clk);
      expect_idle("during reset");
    end
    arst_n = 1'b1;
    @(negedge clk);
    expect_idle("after reset");

    // full words at random places, upper address bits included
    for (int i = 0; i < 16; i++) begin
      addrs[i] = lcg_next() & 32'hffff_fffc;
      store_op(addrs[i], lcg_next(), ST_W, 0, "word store");
    end
    for (int i = 0; i < 16; i++) begin
      load_op(addrs[i], LD_W, 0, "word load");
    end

    // each sub-word store is read back before the next one covers it
    for (int off = 0; off < 4; off++) begin
      base = lcg_next() & 32'hffff_fffc;
      store_op(base, lcg_next(), ST_W, 0, "base word");
      store_op(base + word_t'(off), lcg_next(), ST_B, 0, "byte store");
      load_op(base, LD_W, 0, "byte store result");
      if (off % 2 == 0) begin
        store_op(base + word_t'(off), lcg_next(), ST_H, 0, "half store");
        load_op(base, LD_W, 0, "half store result");
      end
    end

    // k picks whether every byte has its top bit set or clear
    for (int k = 0; k < 2; k++) begin
      for (int off = 0; off < 4; off++) begin
        base = lcg_next() & 32'hffff_fffc;
        data = (k != 0) ? (lcg_next() | 32'h80808080) : (lcg_next() & 32'h7f7f7f7f);
        store_op(base, data, ST_W, 0, "extension word");
        load_op(base + word_t'(off), LD_BS, 0, "byte signed load");
        load_op(base + word_t'(off), LD_BU, 0, "byte unsigned load");
        if (off % 2 == 0) begin
          load_op(base + word_t'(off), LD_HS, 0, "half signed load");
          load_op(base + word_t'(off), LD_HU, 0, "half unsigned load");
        end
      end
    end

    for (int j = 0; j < 4; j++) begin
      base = lcg_next() & 32'hffff_fffc;
      data = lcg_next();
      hold = 1 + int'(lcg_next() % 32'd5);
      store_op(base, data, ST_W, hold, "held store");
      store_op(base, data, ST_W, 0, "store after hold");
      hold = 1 + int'(lcg_next() % 32'd5);
      load_op(base + word_t'(j), LD_BS, hold, "held load");
      load_op(base + word_t'(j), LD_BS, 0, "load after hold");
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  // load request and response
  input  word_t raddr,
  input  func_t rfunc,
  input  logic  rreq_valid,
  output logic  rreq_ready,
  output word_t rdata,
  output logic  rres_valid,
  input  logic  rres_ready,

  // store request and response
  input  word_t waddr,
  input  word_t wdata,
  input  func_t wfunc,
  input  logic  wreq_valid,
  output logic  wreq_ready,
  output logic  wres_valid,
  input  logic  wres_ready
);

  // read side between lsu and memory
  word_t araddr;
  logic  arvalid;
  logic  arready;
  word_t rdata_mem;
  logic  rvalid;
  logic  rready;

  // write side between lsu and memory
  word_t awaddr;
  logic  awvalid;
  logic  awready;
  word_t wdata_mem;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  logic  bvalid;
  logic  bready;

  lsu u_lsu (
    .clk        (clk),
    .arst_n     (arst_n),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .waddr      (waddr),
    .wdata      (wdata),
    .wfunc      (wfunc),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata_mem  (rdata_mem),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata_mem  (wdata_mem),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  data_sram u_data_sram (
    .clk       (clk),
    .arst_n    (arst_n),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata_mem (rdata_mem),
    .rvalid    (rvalid),
    .rready    (rready),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata_mem (wdata_mem),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready)
  );

endmodule

`default_nettype wire

// File: data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  // read address channel
  input  word_t araddr,
  input  logic  arvalid,
  output logic  arready,

  // read data channel
  output word_t rdata_mem,
  output logic  rvalid,
  input  logic  rready,

  // write address channel
  input  word_t awaddr,
  input  logic  awvalid,
  output logic  awready,

  // write data channel
  input  word_t wdata_mem,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,

  // write response channel
  output logic  bvalid,
  input  logic  bready
);

  word_t             mem [MEM_WORDS];
  word_t             rdata_q;
  logic              rpend_q;
  logic              bpend_q;
  logic [MEM_AW-1:0] rindex;
  logic [MEM_AW-1:0] windex;
  logic              ar_fire;
  logic              r_fire;
  logic              w_fire;
  logic              b_fire;

  // word index, upper address bits ignored
  assign rindex = araddr[MEM_AW+1:2];
  assign windex = awaddr[MEM_AW+1:2];

  // one read outstanding at most
  assign arready = ~rpend_q;
  assign rvalid  = rpend_q;
  assign rdata_mem = rdata_q;

  // write channels blocked while the response waits
  assign awready = ~bpend_q;
  assign wready  = ~bpend_q;
  assign bvalid  = bpend_q;

  assign ar_fire = arvalid & arready;
  assign r_fire  = rpend_q & rready;
  assign w_fire  = awvalid & awready & wvalid & wready;
  assign b_fire  = bpend_q & bready;

  // read response word
  // same-cycle write to this word is not seen
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= mem[rindex];
    end
  end

  // byte lane writes
  always_ff @(posedge clk) begin
    if (w_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[windex][8*i +: 8] <= wdata_mem[8*i +: 8];
        end
      end
    end
  end

  // read pending flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rpend_q <= 1'b0;
    end else if (ar_fire) begin
      rpend_q <= 1'b1;
    end else if (r_fire) begin
      rpend_q <= 1'b0;
    end
  end

  // write response pending flag
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bpend_q <= 1'b0;
    end else if (w_fire) begin
      bpend_q <= 1'b1;
    end else if (b_fire) begin
      bpend_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  // core load request and response
  input  word_t raddr,
  input  func_t rfunc,
  input  logic  rreq_valid,
  output logic  rreq_ready,
  output word_t rdata,
  output logic  rres_valid,
  input  logic  rres_ready,

  // core store request and response
  input  word_t waddr,
  input  word_t wdata,
  input  func_t wfunc,
  input  logic  wreq_valid,
  output logic  wreq_ready,
  output logic  wres_valid,
  input  logic  wres_ready,

  // memory read address and data
  output word_t araddr,
  output logic  arvalid,
  input  logic  arready,
  input  word_t rdata_mem,
  input  logic  rvalid,
  output logic  rready,

  // memory write address, data and response
  output word_t awaddr,
  output logic  awvalid,
  input  logic  awready,
  output word_t wdata_mem,
  output strb_t wstrb,
  output logic  wvalid,
  input  logic  wready,
  input  logic  bvalid,
  output logic  bready
);

  logic [1:0] roff_q;
  func_t      rfunc_q;
  logic       rreq_fire;
  word_t      rword_shifted;
  strb_t      wstrb_base;

  // load request goes straight to the read address channel
  assign arvalid    = rreq_valid;
  assign araddr     = raddr;
  assign rreq_ready = arready;
  assign rreq_fire  = rreq_valid & arready;

  // offset and function are needed when the word comes back
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      roff_q  <= 2'b00;
      rfunc_q <= LD_W;
    end else if (rreq_fire) begin
      roff_q  <= raddr[1:0];
      rfunc_q <= rfunc;
    end
  end

  // bring the addressed byte down to lane 0
  always_comb begin
    rword_shifted = rdata_mem >> {roff_q, 3'b000};
  end

  // extend byte or halfword by the stored function
  always_comb begin
    case (rfunc_q)
      LD_BS:   rdata = {{24{rword_shifted[7]}}, rword_shifted[7:0]};
      LD_BU:   rdata = {24'h000000, rword_shifted[7:0]};
      LD_HS:   rdata = {{16{rword_shifted[15]}}, rword_shifted[15:0]};
      LD_HU:   rdata = {16'h0000, rword_shifted[15:0]};
      // LD_W and unknown codes
      default: rdata = rword_shifted;
    endcase
  end

  // load response passes through unchanged
  assign rres_valid = rvalid;
  assign rready     = rres_ready;

  // lanes touched before the offset is applied
  always_comb begin
    case (wfunc)
      ST_B:    wstrb_base = 4'b0001;
      ST_H:    wstrb_base = 4'b0011;
      default: wstrb_base = 4'b1111;
    endcase
  end

  // place data and strobe on the addressed lanes
  always_comb begin
    wdata_mem = wdata << {waddr[1:0], 3'b000};
    wstrb     = wstrb_base << waddr[1:0];
  end

  // address and data channels move as one
  assign awaddr  = waddr;
  assign awvalid = wreq_valid;
  assign wvalid  = wreq_valid;

  // accepted only when both channels take it on the same edge
  assign wreq_ready = awready & wready;

  // store response passes through unchanged
  assign wres_valid = bvalid;
  assign bready     = wres_ready;

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

  // one data or address word
  typedef logic [31:0] word_t;

  // byte write strobe, one bit per lane
  typedef logic [3:0] strb_t;

  // memory function code shared by loads and stores
  typedef logic [2:0] func_t;

  // load functions
  // codes above LD_W fall back to a word load
  localparam func_t LD_BS = 3'd0;
  localparam func_t LD_BU = 3'd1;
  localparam func_t LD_HS = 3'd2;
  localparam func_t LD_HU = 3'd3;
  localparam func_t LD_W  = 3'd4;

  // store functions
  // codes above ST_W fall back to a word store
  localparam func_t ST_B = 3'd0;
  localparam func_t ST_H = 3'd1;
  localparam func_t ST_W = 3'd2;

  // data memory geometry
  localparam int MEM_WORDS = 256;

  // word index width
  // address bits [MEM_AW+1:2] pick the word
  localparam int MEM_AW = $clog2(MEM_WORDS);

endpackage

`default_nettype wire
